// File: src.f
src/spart_pkg.sv
src/baud_gen.sv
src/rx_sampler.sv
src/rx_deframer.sv
src/tx_serializer.sv
src/spart_top.sv
verif/spart_tb.sv

// File: Makefile
SIM        = verilator
TOP        = spart_tb
FILELIST   = src.f
OBJ_DIR    = obj_dir
SIM_FLAGS  = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: verif/spart_tb.sv
`timescale 1ns/1ps

module spart_tb;
  import spart_pkg::*;

  // divisor under test, one tick every 4 clocks
  localparam int baud_setting = 3;
  localparam int tick_clocks  = baud_setting + 1;
  localparam int bit_clocks   = oversample * tick_clocks;
  localparam int frame_clocks = (data_bits + 2) * bit_clocks;
  localparam int wait_limit   = 3 * frame_clocks;
  // outcome codes as {frame_err, overrun, valid}
  localparam logic [2:0] out_none  = 3'b000;
  localparam logic [2:0] out_valid = 3'b001;
  localparam logic [2:0] out_ovr   = 3'b010;
  localparam logic [2:0] out_ferr  = 3'b100;

  logic clk;
  logic rst;
  logic [div_width-1:0] baud_div;
  logic rxd;
  logic txd;
  logic [data_bits-1:0] tx_data;
  logic tx_valid;
  logic tx_credit;
  logic rx_credit;
  logic [data_bits-1:0] rx_data;
  logic rx_valid;
  logic rx_overrun;
  logic rx_frame_err;

  // rxd source, loopback from txd or bit-banged
  logic loop_sel;
  logic bang_rxd;
  // nothing may happen on the outputs while set
  logic quiet;
  string test_name;
  // host side bookkeeping
  logic [data_bits-1:0] exp_q[$];
  logic [data_bits-1:0] exp_head;
  logic [2:0] exp_outcome;
  int rx_held;
  int tx_credits;
  int tx_sent;
  int tx_returned;
  int seed;
  int k;
  logic [31:0] rnd;

  assign rxd = loop_sel ? txd : bang_rxd;

  spart_top i_spart_top (
    .clk          (clk),
    .rst          (rst),
    .baud_div     (baud_div),
    .rxd          (rxd),
    .txd          (txd),
    .tx_data      (tx_data),
    .tx_valid     (tx_valid),
    .tx_credit    (tx_credit),
    .rx_credit    (rx_credit),
    .rx_data      (rx_data),
    .rx_valid     (rx_valid),
    .rx_overrun   (rx_overrun),
    .rx_frame_err (rx_frame_err)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "simulation stopped");
  endtask

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // idle line and no pulses
  a_quiet: assert property (@(posedge clk) disable iff (rst)
    quiet |-> (txd && !tx_credit && !rx_valid && !rx_overrun && !rx_frame_err))
    else fail_run($sformatf("[ERROR] %s: expected txd=1 pulses=0000, got txd=%b pulses=%b",
      test_name, txd, {tx_credit, rx_valid, rx_overrun, rx_frame_err}));

  // every rx pulse must be the one predicted for the frame
  a_outcome: assert property (@(posedge clk) disable iff (rst)
    (rx_valid || rx_overrun || rx_frame_err) |->
      ({rx_frame_err, rx_overrun, rx_valid} == exp_outcome))
    else fail_run($sformatf("[ERROR] %s: expected outcome %b, got %b",
      test_name, exp_outcome, {rx_frame_err, rx_overrun, rx_valid}));

  a_rx_data: assert property (@(posedge clk) disable iff (rst)
    rx_valid |-> (rx_data == exp_head))
    else fail_run($sformatf("[ERROR] %s: expected rx_data %h, got %h",
      test_name, exp_head, rx_data));

  a_rx_credit: assert property (@(posedge clk) disable iff (rst)
    rx_valid |-> (rx_held > 0))
    else fail_run($sformatf("[ERROR] %s: expected rx credits > 0, got %0d",
      test_name, rx_held));

  // host never holds more tx credits than slots, never fewer than none
  a_tx_credit_range: assert property (@(posedge clk) disable iff (rst)
    (tx_credits >= 0) && (tx_credits <= tx_credits_init))
    else fail_run($sformatf("[ERROR] %s: expected tx credits 0..%0d, got %0d",
      test_name, tx_credits_init, tx_credits));

  // returned credits back to the host
  always @(negedge clk) begin
    if (!rst && tx_credit) begin
      tx_credits++;
      tx_returned++;
    end
  end

  //////////////////////////////////////////////////
  // host tasks
  //////////////////////////////////////////////////

  task automatic grant_rx_credit();
    rx_credit = 1'b1;
    rx_held++;
    @(negedge clk);
    rx_credit = 1'b0;
  endtask

  task automatic wait_tx_credit();
    int n;
    n = 0;
    while (tx_credits == 0 && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (n >= wait_limit) begin
      fail_run("timeout waiting for the transmitter to return a credit");
    end
  endtask

  // spends one tx credit
  task automatic send_tx_byte(input logic [data_bits-1:0] data);
    wait_tx_credit();
    tx_data  = data;
    tx_valid = 1'b1;
    tx_credits--;
    tx_sent++;
    @(negedge clk);
    tx_valid = 1'b0;
  endtask

  // predicted outcome from stop bit and credits held
  task automatic expect_frame(input logic [data_bits-1:0] data, input logic stop_ok);
    if (!stop_ok) begin
      exp_outcome = out_ferr;
    end else if (rx_held > 0) begin
      exp_outcome = out_valid;
      exp_q.push_back(data);
      exp_head = exp_q[0];
    end else begin
      exp_outcome = out_ovr;
    end
  endtask

  task automatic wait_rx_outcome();
    int n;
    n = 0;
    while (!(rx_valid || rx_overrun || rx_frame_err) && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (n >= wait_limit) begin
      fail_run("timeout waiting for a receive outcome");
    end else begin
      // pulse gets checked on the next rising edge first
      @(negedge clk);
      if (exp_outcome == out_valid) begin
        void'(exp_q.pop_front());
        rx_held--;
      end
      exp_outcome = out_none;
    end
  endtask

  task automatic bang_frame(input logic [data_bits-1:0] data, input logic stop_ok);
    int i;
    bang_rxd = 1'b0;
    repeat (bit_clocks) @(negedge clk);
    // lsb first
    for (i = 0; i < data_bits; i++) begin
      bang_rxd = data[i];
      repeat (bit_clocks) @(negedge clk);
    end
    if (stop_ok) begin
      bang_rxd = 1'b1;
      repeat (bit_clocks) @(negedge clk);
    end else begin
      // bad stop held low just past its sample point
      // a full low bit would leave 8 low ticks after it and fake a start
      bang_rxd = 1'b0;
      repeat (bit_clocks * 3 / 4) @(negedge clk);
      bang_rxd = 1'b1;
      repeat (bit_clocks / 4) @(negedge clk);
    end
    repeat (bit_clocks) @(negedge clk);
  endtask

  task automatic loop_frame(input logic [data_bits-1:0] data);
    expect_frame(data, 1'b1);
    send_tx_byte(data);
    wait_rx_outcome();
  endtask

  task automatic banged_frame(input logic [data_bits-1:0] data, input logic stop_ok);
    expect_frame(data, stop_ok);
    fork
      bang_frame(data, stop_ok);
      wait_rx_outcome();
    join
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    rst         = 1'b1;
    baud_div    = div_width'(baud_setting);
    tx_data     = '0;
    tx_valid    = 1'b0;
    rx_credit   = 1'b0;
    loop_sel    = 1'b1;
    bang_rxd    = 1'b1;
    quiet       = 1'b1;
    test_name   = "reset_idle";
    exp_head    = '0;
    exp_outcome = out_none;
    rx_held     = rx_credits_init;
    tx_credits  = tx_credits_init;
    tx_sent     = 0;
    tx_returned = 0;
    seed        = 1;
    repeat (3) @(negedge clk);
    rst = 1'b0;

    // outputs idle with no stimulus
    repeat (2 * frame_clocks) @(negedge clk);
    quiet = 1'b0;

    test_name = "loopback";
    for (k = 0; k < 20; k++) begin
      rnd = $random(seed);
      grant_rx_credit();
      loop_frame(rnd[data_bits-1:0]);
    end

    // no credit left, byte is dropped
    test_name = "overrun";
    rnd = $random(seed);
    loop_frame(rnd[data_bits-1:0]);
    grant_rx_credit();
    rnd = $random(seed);
    loop_frame(rnd[data_bits-1:0]);

    // credit survives the bad frame and carries the next one
    test_name = "frame_error";
    loop_sel = 1'b0;
    grant_rx_credit();
    rnd = $random(seed);
    banged_frame(rnd[data_bits-1:0], 1'b0);
    rnd = $random(seed);
    banged_frame(rnd[data_bits-1:0], 1'b1);

    // asymmetric byte, reversed order would read d2
    test_name = "bit_order";
    grant_rx_credit();
    banged_frame(8'h4b, 1'b1);

    // 5 low ticks, short of start_qual
    test_name = "glitch";
    quiet = 1'b1;
    bang_rxd = 1'b0;
    repeat (5 * tick_clocks) @(negedge clk);
    bang_rxd = 1'b1;
    repeat (2 * frame_clocks) @(negedge clk);
    quiet = 1'b0;

    test_name = "tx_credit_count";
    wait_tx_credit();
    if (tx_returned != tx_sent) begin
      fail_run($sformatf("[ERROR] %s: expected %0d credits returned, got %0d",
        test_name, tx_sent, tx_returned));
    end else if (exp_q.size() != 0) begin
      fail_run($sformatf("[ERROR] %s: expected 0 bytes pending, got %0d",
        test_name, exp_q.size()));
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

// File: src/spart_top.sv
`timescale 1ns/1ps

module spart_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [spart_pkg::div_width-1:0] baud_div,
  input  logic                            rxd,
  output logic                            txd,
  input  logic [spart_pkg::data_bits-1:0] tx_data,
  input  logic                            tx_valid,
  output logic                            tx_credit,
  input  logic                            rx_credit,
  output logic [spart_pkg::data_bits-1:0] rx_data,
  output logic                            rx_valid,
  output logic                            rx_overrun,
  output logic                            rx_frame_err
);

  // shared 16x strobe
  logic tick;
  // sampler to deframer
  logic line;
  logic bit_start;
  logic bit_sample;

  //////////////////////////////////////////////////
  // tick generator
  //////////////////////////////////////////////////

  baud_gen i_baud_gen (
    .clk      (clk),
    .rst      (rst),
    .baud_div (baud_div),
    .tick     (tick)
  );

  //////////////////////////////////////////////////
  // receive chain
  //////////////////////////////////////////////////

  rx_sampler i_rx_sampler (
    .clk        (clk),
    .rst        (rst),
    .tick       (tick),
    .rxd        (rxd),
    .line       (line),
    .bit_start  (bit_start),
    .bit_sample (bit_sample)
  );

  rx_deframer i_rx_deframer (
    .clk          (clk),
    .rst          (rst),
    .line         (line),
    .bit_start    (bit_start),
    .bit_sample   (bit_sample),
    .rx_credit    (rx_credit),
    .rx_data      (rx_data),
    .rx_valid     (rx_valid),
    .rx_overrun   (rx_overrun),
    .rx_frame_err (rx_frame_err)
  );

  //////////////////////////////////////////////////
  // transmitter
  //////////////////////////////////////////////////

  tx_serializer i_tx_serializer (
    .clk       (clk),
    .rst       (rst),
    .tick      (tick),
    .tx_data   (tx_data),
    .tx_valid  (tx_valid),
    .txd       (txd),
    .tx_credit (tx_credit)
  );

endmodule

// File: src/tx_serializer.sv
`timescale 1ns/1ps

module tx_serializer (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            tick,
  input  logic [spart_pkg::data_bits-1:0] tx_data,
  input  logic                            tx_valid,
  output logic                            txd,
  output logic                            tx_credit
);
  import spart_pkg::*;

  // stop, data, start; bit 0 goes out next
  logic [data_bits+1:0] frame;
  // slot full
  logic busy;
  // first tick seen, start bit on the line
  logic started;
  logic [$clog2(oversample)-1:0] tick_cnt;
  // 0 start, 1..8 data, 9 stop
  logic [$clog2(data_bits + 2)-1:0] bit_cnt;
  logic bit_done;
  logic last_bit;
  logic shift;

  assign bit_done = started && (int'(tick_cnt) == oversample - 1);
  assign last_bit = int'(bit_cnt) == data_bits + 1;
  // next bit onto the line
  assign shift = busy && tick && (!started || (bit_done && !last_bit));

  //////////////////////////////////////////////////
  // frame register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (tx_valid && !busy) begin
      frame <= {1'b1, tx_data, 1'b0};
    end else if (shift) begin
      frame <= {1'b1, frame[data_bits+1:1]};
    end
  end

  //////////////////////////////////////////////////
  // bit timing and credit return
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy      <= 1'b0;
      started   <= 1'b0;
      tick_cnt  <= '0;
      bit_cnt   <= '0;
      txd       <= 1'b1;
      tx_credit <= 1'b0;
    end else begin
      tx_credit <= 1'b0;
      if (!busy) begin
        busy    <= tx_valid;
        started <= 1'b0;
      end else if (tick) begin
        if (!started) begin
          // start bit begins on the first tick
          started  <= 1'b1;
          txd      <= frame[0];
          tick_cnt <= '0;
          bit_cnt  <= '0;
        end else if (bit_done) begin
          tick_cnt <= '0;
          if (last_bit) begin
            // full stop bit sent, slot free again
            busy      <= 1'b0;
            started   <= 1'b0;
            txd       <= 1'b1;
            tx_credit <= 1'b1;
          end else begin
            txd     <= frame[0];
            bit_cnt <= bit_cnt + 1'b1;
          end
        end else begin
          tick_cnt <= tick_cnt + 1'b1;
        end
      end
    end
  end

  // host credit rule keeps tx_valid off a busy slot
  a_no_accept_busy: assert property (
    @(posedge clk) disable iff (rst) tx_valid |-> !busy
  );

endmodule

// File: src/rx_deframer.sv
`timescale 1ns/1ps

module rx_deframer (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            line,
  input  logic                            bit_start,
  input  logic                            bit_sample,
  input  logic                            rx_credit,
  output logic [spart_pkg::data_bits-1:0] rx_data,
  output logic                            rx_valid,
  output logic                            rx_overrun,
  output logic                            rx_frame_err
);
  import spart_pkg::*;

  // byte under assembly
  logic [data_bits-1:0] shreg;
  // data bits taken so far, data_bits means stop is next
  logic [$clog2(data_bits + 1)-1:0] bit_cnt;
  // slots granted by the host and not yet used
  logic [credit_width-1:0] credits;
  logic stop_seen;
  logic has_credit;
  logic grant;
  logic spend;

  //////////////////////////////////////////////////
  // byte assembly
  //////////////////////////////////////////////////

  assign stop_seen = bit_sample && (int'(bit_cnt) == data_bits);

  // lsb arrives first, shift right
  always_ff @(posedge clk) begin
    if (bit_sample && !stop_seen) begin
      shreg <= {line, shreg[data_bits-1:1]};
    end
  end

  // stays put from the stop sample until the next frame
  assign rx_data = shreg;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bit_cnt <= '0;
    end else if (bit_start) begin
      bit_cnt <= '0;
    end else if (bit_sample && !stop_seen) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // credit accounting and delivery
  //////////////////////////////////////////////////

  assign has_credit = credits != '0;
  // grants past the top are lost
  assign grant = rx_credit && (credits != '1);
  assign spend = stop_seen && line && has_credit;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      credits <= credit_width'(rx_credits_init);
    end else begin
      case ({grant, spend})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        // grant and delivery together cancel
        default: credits <= credits;
      endcase
    end
  end

  // outcome pulses one clock after the stop sample
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rx_valid     <= 1'b0;
      rx_overrun   <= 1'b0;
      rx_frame_err <= 1'b0;
    end else begin
      rx_valid     <= spend;
      // good frame but nowhere to put it
      rx_overrun   <= stop_seen && line && !has_credit;
      // bad stop bit, no credit spent
      rx_frame_err <= stop_seen && !line;
    end
  end

  // delivery only on a credit held the cycle before
  a_valid_needs_credit: assert property (
    @(posedge clk) disable iff (rst) rx_valid |-> ($past(credits) != '0)
  );

  a_one_outcome: assert property (
    @(posedge clk) disable iff (rst) $onehot0({rx_valid, rx_overrun, rx_frame_err})
  );

endmodule

// File: src/rx_sampler.sv
`timescale 1ns/1ps

module rx_sampler (
  input  logic clk,
  input  logic rst,
  input  logic tick,
  input  logic rxd,
  output logic line,
  output logic bit_start,
  output logic bit_sample
);
  import spart_pkg::*;

  typedef enum logic {
    st_hunt,
    st_frame
  } state_t;

  // two-flop synchronizer, idle level high
  logic [1:0] sync;
  state_t state;
  // consecutive low ticks while hunting
  logic [$clog2(start_qual)-1:0] low_cnt;
  // ticks into the current bit
  logic [$clog2(oversample)-1:0] tick_cnt;
  // bit index, 0..7 data then stop
  logic [$clog2(data_bits + 1)-1:0] bit_cnt;
  logic last_bit;

  //////////////////////////////////////////////////
  // line synchronizer
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sync <= 2'b11;
    end else begin
      sync <= {sync[0], rxd};
    end
  end

  assign line = sync[1];

  //////////////////////////////////////////////////
  // start qualification and bit strobes
  //////////////////////////////////////////////////

  // start confirmed on the eighth low tick
  assign bit_start = tick && (state == st_hunt) && !line &&
                     (int'(low_cnt) == start_qual - 1);

  // one strobe per full bit period after start
  assign bit_sample = tick && (state == st_frame) &&
                      (int'(tick_cnt) == oversample - 1);

  // stop bit is the ninth strobe
  assign last_bit = int'(bit_cnt) == data_bits;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= st_hunt;
      low_cnt  <= '0;
      tick_cnt <= '0;
      bit_cnt  <= '0;
    end else if (tick) begin
      case (state)
        st_hunt: begin
          if (line) begin
            // glitch or idle, start over
            low_cnt <= '0;
          end else if (bit_start) begin
            state    <= st_frame;
            low_cnt  <= '0;
            tick_cnt <= '0;
            bit_cnt  <= '0;
          end else begin
            low_cnt <= low_cnt + 1'b1;
          end
        end
        st_frame: begin
          if (bit_sample) begin
            tick_cnt <= '0;
            if (last_bit) begin
              // stop sampled, back to hunting
              state <= st_hunt;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end else begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        default: state <= st_hunt;
      endcase
    end
  end

  // start and sample strobes never collide
  a_no_overlap: assert property (
    @(posedge clk) disable iff (rst) !(bit_start && bit_sample)
  );

  // strobes are single-cycle whatever the divisor
  a_start_pulse: assert property (
    @(posedge clk) disable iff (rst) bit_start |=> !bit_start
  );
  a_sample_pulse: assert property (
    @(posedge clk) disable iff (rst) bit_sample |=> !bit_sample
  );

endmodule

// File: src/baud_gen.sv
`timescale 1ns/1ps

module baud_gen (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [spart_pkg::div_width-1:0] baud_div,
  output logic                         tick
);
  import spart_pkg::*;

  // ticks left until the next strobe
  logic [div_width-1:0] cnt;

  //////////////////////////////////////////////////
  // 16x strobe generator
  //////////////////////////////////////////////////

  // down-counter, reload on zero
  // period is baud_div + 1 clocks
  // new divisor only picked up at reload
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else if (cnt == '0) begin
      cnt  <= baud_div;
      tick <= 1'b1;
    end else begin
      cnt  <= cnt - 1'b1;
      tick <= 1'b0;
    end
  end

endmodule

// File: src/spart_pkg.sv
package spart_pkg;

  //////////////////////////////////////////////////
  // frame shape
  //////////////////////////////////////////////////

  // data bits per frame, sent lsb first
  localparam int data_bits = 8;

  //////////////////////////////////////////////////
  // oversampling
  //////////////////////////////////////////////////

  // ticks per bit period
  localparam int oversample = 16;
  // consecutive low ticks to confirm a start bit
  // lands the sample point near mid-bit
  localparam int start_qual = 8;
  // host baud divisor width
  localparam int div_width = 16;

  //////////////////////////////////////////////////
  // credit flow control
  //////////////////////////////////////////////////

  // rx credit counter, saturates at all ones
  localparam int credit_width = 4;
  // host side tx credits, one per tx holding slot
  localparam int tx_credits_init = 1;
  // rx credits held by the deframer out of reset
  localparam int rx_credits_init = 0;

endpackage
